/* project.f */
logic/floatFormatPkg.sv
logic/motorPkg.sv
logic/doubleDivider.sv
logic/degToSteps.sv
logic/stepPulser.sv
logic/stepperAxes.sv
tests/stepperAxesTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass message.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module stepperAxesTb -o stepperAxesSim

output="$(./obj_dir/stepperAxesSim)"
echo "$output"

if grep -qx "Verification passed" <<< "$output"; then
  exit 0
else
  exit 1
fi

/* tests/stepperAxesTb.sv */
`default_nettype none

module stepperAxesTb;

  ////////////////////////////////////////
  // Timing of the DUT and the run.
  ////////////////////////////////////////
  localparam int DIV_LATENCY = 58;  // Cycles from the sampled en to dataReady.
  localparam int STEP_PERIOD = 4;   // Cycles from one step pulse to the next.
  localparam int RESET_CYCLES = 5;
  localparam int MAX_ROWS = 16;

  logic        clk = 1'b0;
  logic        reset;
  logic        en;
  logic [63:0] dth1;
  logic [63:0] dth2;
  logic        busy;
  logic        dataReady;
  logic        step1;
  logic        dir1;
  logic        busy1;
  logic        step2;
  logic        dir2;
  logic        busy2;

  // Stimulus table, one entry per row, with the expected results next to it.
  string rowName   [MAX_ROWS];
  real   angle1    [MAX_ROWS];
  real   angle2    [MAX_ROWS];
  logic  reEnable  [MAX_ROWS];  // Pulse en again while the dividers work.
  int    expCount1 [MAX_ROWS];
  int    expCount2 [MAX_ROWS];
  logic  expDir1   [MAX_ROWS];
  logic  expDir2   [MAX_ROWS];
  int    numRows = 0;

  int errorCount = 0;
  int checkCount = 0;
  int cycleCount = 0;
  int timeoutLimit = 0;  // Set at time zero from the table.

  stepperAxes uut (
    .clk       (clk),
    .reset     (reset),
    .en        (en),
    .dth1      (dth1),
    .dth2      (dth2),
    .busy      (busy),
    .dataReady (dataReady),
    .step1     (step1),
    .dir1      (dir1),
    .busy1     (busy1),
    .step2     (step2),
    .dir2      (dir2),
    .busy2     (busy2)
  );

  always #50 clk = ~clk;  // Period of 100.

  // Watchdog on the total cycle count.
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutLimit) begin
      $display("Timeout after %0d cycles, the DUT never went idle.", cycleCount);
      $display("Verification failed");
      $finish;
    end
  end

  // Whole steps for an angle in degrees, rounded half up.
  function automatic int roundSteps(real angle);
    real quotient;
    quotient = (angle < 0.0 ? -angle : angle) / 1.8;
    return $rtoi($floor(quotient + 0.5));
  endfunction

  task automatic addRow(string name, real a1, real a2, logic again);
    rowName[numRows] = name;
    angle1[numRows] = a1;
    angle2[numRows] = a2;
    reEnable[numRows] = again;
    expCount1[numRows] = roundSteps(a1);
    expCount2[numRows] = roundSteps(a2);
    expDir1[numRows] = (a1 < 0.0);  // A negative move sets dir.
    expDir2[numRows] = (a2 < 0.0);
    numRows++;
  endtask

  task automatic checkEqual(string name, string what, int expected, int actual);
    checkCount++;
    if (expected != actual) begin
      errorCount++;
      $display("** Error %s: %s expected %0d, actual %0d", name, what, expected, actual);
    end
  endtask

  // Inputs change and outputs are read 10 units after the rising edge.
  task automatic nextCycle();
    @(posedge clk);
    #10;
  endtask

  ////////////////////////////////////////
  // Main sequence.
  ////////////////////////////////////////
  initial begin
    int   gap;
    int   latency;
    int   pulses1;
    int   pulses2;
    int   dirErr1;
    int   dirErr2;
    logic rose1;
    logic rose2;
    void'($urandom(32'h6177));
    reset = 1'b1;
    en = 1'b0;
    dth1 = '0;
    dth2 = '0;
    addRow("posBoth", 90.0, 9.0, 1'b0);
    addRow("negBoth", -45.0, -18.0, 1'b0);
    addRow("mixedSign", 27.0, -36.0, 1'b0);
    addRow("zeroAxis1", 0.0, 12.6, 1'b0);
    addRow("zeroBoth", 0.0, 0.0, 1'b0);
    addRow("rounding", 5.0, -2.9, 1'b0);    // 2.78 rounds up, 1.61 rounds up.
    addRow("belowHalf", 0.5, -1.0, 1'b0);   // 0.28 gives no step at all.
    addRow("secondEn", 54.0, -72.0, 1'b1);
    addRow("wideMove", 360.0, -180.0, 1'b0);
    // Each row needs the division, the load and the longer pulse train, plus margin.
    timeoutLimit = RESET_CYCLES;
    for (int i = 0; i < numRows; i++) begin
      timeoutLimit += DIV_LATENCY + 4 + STEP_PERIOD * (expCount1[i] > expCount2[i] ?
                      expCount1[i] : expCount2[i]) + 10;
    end

    repeat (RESET_CYCLES) @(posedge clk);
    #10;
    reset = 1'b0;
    checkEqual("reset", "output bits", 0,
               int'({busy, dataReady, step1, dir1, busy1, step2, dir2, busy2}));

    for (int i = 0; i < numRows; i++) begin
      gap = int'($urandom % 4);
      repeat (gap) nextCycle();             // Random idle time between rows.
      dth1 = $realtobits(angle1[i]);
      dth2 = $realtobits(angle2[i]);
      en = 1'b1;
      nextCycle();                          // en is sampled at this edge.
      en = 1'b0;

      // Count cycles to dataReady, busy must hold high until then.
      latency = 0;
      while (!dataReady && latency <= DIV_LATENCY + 4) begin
        checkEqual(rowName[i], "busy while dividing", 1, int'(busy));
        if (reEnable[i] && latency == 20) begin
          en = 1'b1;                        // Must be ignored, the dividers are busy.
          dth1 = $realtobits(3.6);
          dth2 = $realtobits(3.6);
        end else begin
          en = 1'b0;
        end
        nextCycle();
        latency++;
      end
      checkEqual(rowName[i], "cycles from en to dataReady", DIV_LATENCY, latency);
      checkEqual(rowName[i], "busy with dataReady", 0, int'(busy));

      // The first cycle is the load, then pulses until both axes are idle.
      pulses1 = 0;
      pulses2 = 0;
      dirErr1 = 0;
      dirErr2 = 0;
      rose1 = 1'b0;
      rose2 = 1'b0;
      do begin
        nextCycle();
        pulses1 += int'(step1);
        pulses2 += int'(step2);
        dirErr1 += int'(dir1 != expDir1[i]);  // dir must hold for the whole train.
        dirErr2 += int'(dir2 != expDir2[i]);
        rose1 |= busy1;
        rose2 |= busy2;
      end while (busy1 || busy2);
      checkEqual(rowName[i], "axis 1 pulses", expCount1[i], pulses1);
      checkEqual(rowName[i], "axis 2 pulses", expCount2[i], pulses2);
      checkEqual(rowName[i], "axis 1 cycles with wrong dir", 0, dirErr1);
      checkEqual(rowName[i], "axis 2 cycles with wrong dir", 0, dirErr2);
      checkEqual(rowName[i], "axis 1 busy rose", int'(expCount1[i] != 0), int'(rose1));
      checkEqual(rowName[i], "axis 2 busy rose", int'(expCount2[i] != 0), int'(rose2));
    end

    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/stepperAxes.sv */
`default_nettype none

// Two-axis stepper front end from angle change to step and direction lines.
module stepperAxes (
  input  logic        clk,
  input  logic        reset,
  input  logic        en,         // Starts a move of both axes.
  input  logic [63:0] dth1,       // Angle changes as doubles in degrees.
  input  logic [63:0] dth2,
  output logic        busy,       // Conversion in progress.
  output logic        dataReady,  // Step counts are loaded into the pulsers.
  output logic        step1,
  output logic        dir1,
  output logic        busy1,
  output logic        step2,
  output logic        dir2,
  output logic        busy2
);

  logic [63:0] stepsAxis1;
  logic [63:0] stepsAxis2;
  logic        dirAxis1;
  logic        dirAxis2;

  degToSteps converter (
    .clk       (clk),
    .reset     (reset),
    .en        (en),
    .dth1      (dth1),
    .dth2      (dth2),
    .dataReady (dataReady),
    .busy      (busy),
    .steps1    (stepsAxis1),
    .dir1      (dirAxis1),
    .steps2    (stepsAxis2),
    .dir2      (dirAxis2)
  );

  ////////////////////////////////////////
  // One pulse generator per axis.
  ////////////////////////////////////////
  stepPulser axis1Pulser (
    .clk       (clk),
    .reset     (reset),
    .load      (dataReady),
    .dirIn     (dirAxis1),
    .magnitude (stepsAxis1),
    .step      (step1),
    .dir       (dir1),
    .busy      (busy1)
  );

  stepPulser axis2Pulser (
    .clk       (clk),
    .reset     (reset),
    .load      (dataReady),
    .dirIn     (dirAxis2),
    .magnitude (stepsAxis2),
    .step      (step2),
    .dir       (dir2),
    .busy      (busy2)
  );

endmodule

`default_nettype wire

/* logic/stepPulser.sv */
`default_nettype none

// Rounds a step magnitude to a whole count and plays it out as step pulses.
module stepPulser import floatFormatPkg::*, motorPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        load,       // Takes a new move, replacing any move in progress.
  input  logic        dirIn,
  input  logic [63:0] magnitude,  // Positive step count as a double.
  output logic        step,       // One cycle pulse per step.
  output logic        dir,
  output logic        busy
);

  doubleWord                     magWord;
  logic [EXP_WIDTH-1:0]          shiftR;     // Right shift that leaves twice the value.
  logic [MANT_WIDTH:0]           halfSteps;  // Value times two, truncated.
  logic [STEP_COUNT_WIDTH-1:0]   count;
  logic [STEP_COUNT_WIDTH-1:0]   remaining;  // Pulses still to send.
  logic [STEP_PERIOD_WIDTH-1:0]  periodCnt;

  ////////////////////////////////////////
  // Double to rounded integer.
  ////////////////////////////////////////
  // The significand holds the value scaled by 2^52. Shifting it right by
  // 1074 minus the exponent leaves the value with one fraction bit.
  always_comb begin
    magWord.raw = magnitude;
    halfSteps = '0;
    shiftR = EXP_BIAS + EXP_WIDTH'(MANT_WIDTH - 1) - magWord.field.exponent;
    if (magWord.field.exponent >= EXP_BIAS - 1'b1) begin  // Below 0.5 stays zero.
      halfSteps = {1'b1, magWord.field.mantissa} >> shiftR;
    end
    // Round half up by adding the fraction bit. Counts above 16 bits wrap.
    count = halfSteps[STEP_COUNT_WIDTH:1] + STEP_COUNT_WIDTH'(halfSteps[0]);
  end

  ////////////////////////////////////////
  // Pulse train.
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      step <= 1'b0;
      dir <= 1'b0;
      busy <= 1'b0;
      remaining <= '0;
      periodCnt <= '0;
    end else begin
      step <= 1'b0;
      if (load) begin
        dir <= dirIn;            // Direction only moves here.
        remaining <= count;
        periodCnt <= '0;
        busy <= (count != '0);   // Nothing to do for a zero move.
      end else if (busy) begin
        if (remaining == '0) begin
          busy <= 1'b0;          // Falls right after the last pulse.
        end else if (periodCnt == STEP_PERIOD_WIDTH'(STEP_PERIOD - 1)) begin
          step <= 1'b1;
          periodCnt <= '0;
          remaining <= remaining - 1'b1;
        end else begin
          periodCnt <= periodCnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/degToSteps.sv */
`default_nettype none

// Turns two angle changes in degrees into step quotients of the 1.8 degree motor.
// Each quotient is split into a positive magnitude and a direction level.
module degToSteps import floatFormatPkg::*, motorPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        en,         // Starts both divisions.
  input  logic [63:0] dth1,       // Angle change of axis 1, double in degrees.
  input  logic [63:0] dth2,       // Angle change of axis 2.
  output logic        dataReady,
  output logic        busy,
  output logic [63:0] steps1,     // Step magnitude of axis 1 as a double.
  output logic        dir1,       // High for a negative move.
  output logic [63:0] steps2,
  output logic        dir2
);

  logic [63:0] quot1;
  logic [63:0] quot2;
  logic        ready1;
  logic        ready2;
  doubleWord   q1Word;
  doubleWord   q2Word;
  doubleWord   mag1Word;
  doubleWord   mag2Word;

  ////////////////////////////////////////
  // Angle over step angle.
  ////////////////////////////////////////
  doubleDivider axis1Div (
    .clk       (clk),
    .reset     (reset),
    .enable    (en),
    .dataa     (dth1),
    .datab     (STEP_ANGLE),
    .dataReady (ready1),
    .busy      (busy),  // Both dividers start together, so one busy covers both.
    .result    (quot1)
  );

  doubleDivider axis2Div (
    .clk       (clk),
    .reset     (reset),
    .enable    (en),
    .dataa     (dth2),
    .datab     (STEP_ANGLE),
    .dataReady (ready2),
    .busy      (),
    .result    (quot2)
  );

  // The divider results are registered, so these hold until the next result.
  always_comb begin
    q1Word.raw = quot1;
    q2Word.raw = quot2;
    mag1Word = q1Word;
    mag2Word = q2Word;
    mag1Word.field.sign = 1'b0;  // Absolute value.
    mag2Word.field.sign = 1'b0;
    steps1 = mag1Word.raw;
    steps2 = mag2Word.raw;
    dir1 = q1Word.field.sign;
    dir2 = q2Word.field.sign;
  end

  assign dataReady = ready1 & ready2;  // Same latency, so both strobe in one cycle.

endmodule

`default_nettype wire

/* logic/doubleDivider.sv */
`default_nettype none

// Divides two IEEE doubles with a restoring loop, one quotient bit per cycle.
// The result appears a fixed DIV_LATENCY cycles after the start.
module doubleDivider import floatFormatPkg::*, motorPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        enable,     // Start strobe, ignored while busy.
  input  logic [63:0] dataa,      // Dividend.
  input  logic [63:0] datab,      // Divisor.
  output logic        dataReady,  // One cycle high when result is new.
  output logic        busy,
  output logic [63:0] result
);

  doubleWord aWord;
  doubleWord bWord;
  doubleWord resWord;

  logic [MANT_WIDTH+1:0]      rem;       // Partial remainder, always below twice the divisor.
  logic [MANT_WIDTH:0]        divisor;   // Divisor mantissa with hidden one.
  logic [MANT_WIDTH+1:0]      quot;      // Integer bit on top, then 53 fraction bits.
  logic [EXP_WIDTH+1:0]       expQ;      // Biased exponent before normalization.
  logic                       signQ;
  logic                       zeroQ;     // Dividend was exact zero.
  logic [MANT_WIDTH-1:0]      normMant;
  logic [EXP_WIDTH-1:0]       normExp;
  logic [DIV_COUNT_WIDTH-1:0] cnt;       // Cycles since the start.

  assign aWord.raw = dataa;
  assign bWord.raw = datab;

  // Pack the normalized fields into the outgoing word.
  always_comb begin
    resWord.field.sign = signQ;
    resWord.field.exponent = normExp;
    resWord.field.mantissa = normMant;
  end

  ////////////////////////////////////////
  // Control and datapath.
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    dataReady <= 1'b0;  // Strobe lasts a single cycle.
    if (reset) begin
      busy <= 1'b0;
      cnt <= '0;
      result <= '0;
    end else if (!busy) begin
      if (enable) begin
        busy <= 1'b1;
        cnt <= '0;
        signQ <= aWord.field.sign ^ bWord.field.sign;
        zeroQ <= (aWord.field.exponent == '0);  // Denormals are out of range, so this is zero.
        // Exponent difference is rebiased once here.
        expQ <= {2'b00, aWord.field.exponent} - {2'b00, bWord.field.exponent}
                + {2'b00, EXP_BIAS};
        rem <= {1'b0, 1'b1, aWord.field.mantissa};
        divisor <= {1'b1, bWord.field.mantissa};
        quot <= '0;
      end
    end else begin
      cnt <= cnt + 1'b1;

      // One restoring step per cycle for the first 54 cycles.
      if (cnt < DIV_COUNT_WIDTH'(MANT_WIDTH + 2)) begin
        if (rem >= {1'b0, divisor}) begin
          rem <= (rem - {1'b0, divisor}) << 1;  // Subtract fits, keep it.
          quot <= {quot[MANT_WIDTH:0], 1'b1};
        end else begin
          rem <= rem << 1;                      // Restore by not subtracting.
          quot <= {quot[MANT_WIDTH:0], 1'b0};
        end
      end

      // The quotient of two mantissas lies between 0.5 and 2.
      // A clear integer bit means one left shift and one less in the exponent.
      if (cnt == DIV_COUNT_WIDTH'(MANT_WIDTH + 2)) begin
        if (quot[MANT_WIDTH+1]) begin
          normMant <= quot[MANT_WIDTH:1];  // Lowest bit is dropped.
          normExp <= expQ[EXP_WIDTH-1:0];
        end else begin
          normMant <= quot[MANT_WIDTH-1:0];
          normExp <= expQ[EXP_WIDTH-1:0] - 1'b1;
        end
      end

      // The remaining cycles are padding up to the fixed latency.
      if (cnt == DIV_COUNT_WIDTH'(DIV_LATENCY - 1)) begin
        busy <= 1'b0;
        dataReady <= 1'b1;
        result <= zeroQ ? '0 : resWord.raw;  // Held until the next division ends.
      end
    end
  end

endmodule

`default_nettype wire

/* logic/motorPkg.sv */
`default_nettype none

// Motor geometry and the timing of the step front end.
package motorPkg;

  ////////////////////////////////////////
  // Motor.
  ////////////////////////////////////////
  localparam logic [63:0] STEP_ANGLE = 64'h3FFC_CCCC_CCCC_CCCD;  // 1.8 degrees per step.

  ////////////////////////////////////////
  // Divider timing.
  ////////////////////////////////////////
  // Cycles from the start of a division to its result strobe.
  // It must leave room for 54 quotient bits and the normalize cycle.
  localparam int DIV_LATENCY = 58;
  localparam int DIV_COUNT_WIDTH = $clog2(DIV_LATENCY);  // Width of the divider cycle count.

  ////////////////////////////////////////
  // Pulse output.
  ////////////////////////////////////////
  localparam int STEP_PERIOD = 4;                          // Cycles from one pulse to the next.
  localparam int STEP_PERIOD_WIDTH = $clog2(STEP_PERIOD);  // Width of the period counter.
  localparam int STEP_COUNT_WIDTH = 16;                    // Largest move is 65535 steps.

endpackage

`default_nettype wire

/* logic/floatFormatPkg.sv */
`default_nettype none

// Layout of an IEEE-754 double precision word.
package floatFormatPkg;

  ////////////////////////////////////////
  // Field widths and bias.
  ////////////////////////////////////////
  localparam int EXP_WIDTH = 11;   // Biased exponent bits.
  localparam int MANT_WIDTH = 52;  // Stored fraction bits, hidden one not included.
  localparam logic [EXP_WIDTH-1:0] EXP_BIAS = EXP_WIDTH'(1023);  // Exponent of 1.0.

  // The three fields of a double, sign on top.
  typedef struct packed {
    logic                  sign;
    logic [EXP_WIDTH-1:0]  exponent;
    logic [MANT_WIDTH-1:0] mantissa;
  } doubleFields;

  // One 64-bit word seen either as plain bits or as its fields.
  typedef union packed {
    logic [63:0] raw;
    doubleFields field;
  } doubleWord;

endpackage

`default_nettype wire
